// ==== filelist.f ====
logic/binarize_pkg.sv
logic/delay_line.sv
logic/line_tap_buffer.sv
logic/window_sum.sv
logic/threshold_decide.sv
logic/adaptive_binarize_top.sv
test/binarize_props.sv
test/adaptive_binarize_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= adaptive_binarize_tb
SEED_ARGS ?= +verilator+seed+1
RUN_ARGS  ?= +verilator+error+limit+100
VFLAGS    ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir

SOURCES := $(shell cat filelist.f)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): filelist.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f filelist.f

run: $(SIM)
	./$(SIM) $(SEED_ARGS) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/adaptive_binarize_tb.sv ====
`timescale 1ns/1ns

module adaptive_binarize_tb
  import binarize_pkg::*;
();

  localparam int COLS     = 20;
  localparam int ROWS     = 16;
  localparam int OUT_COLS = COLS - (WIN - 1);
  localparam int N_RES    = (ROWS - (WIN - 1)) * OUT_COLS;
  localparam int TIMEOUT  = 400;

  logic     clk;
  logic     rst_n;
  logic     i_frame_start;
  logic     i_pix_valid;
  pixel_t   i_pix;
  box_sum_t i_offset;
  logic     o_bin_valid;
  logic     o_bin;
  logic     o_frame_done;
  logic     pix_interior;  // the driven pixel completes an interior window
  logic     pattern_mode;
  box_sum_t cur_offset;
  pixel_t   img [ROWS][COLS];
  int       res_total = 0;
  int       done_total = 0;
  int       frame_base;
  int       done_base;

  adaptive_binarize_top #(.COLS(COLS), .ROWS(ROWS)) adaptive_binarize_top_inst (.*);

  bind adaptive_binarize_top binarize_props #(.COLS(COLS), .ROWS(ROWS)) props_inst (
    .clk(clk), .rst_n(rst_n), .i_frame_start(i_frame_start),
    .i_pix_interior(adaptive_binarize_tb.pix_interior),
    .i_bin_valid(o_bin_valid), .i_frame_done(o_frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  // the window ends at (r, c) and its centre sits six rows and columns back
  function automatic logic expected_bit(input int r, input int c, input box_sum_t offset);
    int sum;
    int centre;
    sum = 0;
    for (int y = r - (WIN - 1); y <= r; y++) begin
      for (int x = c - (WIN - 1); x <= c; x++) begin
        sum += int'(img[y][x]);
      end
    end
    centre = int'(img[r - WIN_HALF][c - WIN_HALF]);
    return (centre * WIN_AREA >= sum + int'(offset));
  endfunction

  task automatic send_frame(input box_sum_t offset, input bit with_gaps);
    frame_base    = res_total;
    done_base     = done_total;
    cur_offset    = offset;
    i_offset      = offset;
    i_frame_start = 1'b1;
    next_cycle();
    i_frame_start = 1'b0;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        i_pix_valid  = 1'b1;
        i_pix        = img[r][c];
        pix_interior = (r >= WIN - 1) && (c >= WIN - 1);
        next_cycle();
        i_pix_valid  = 1'b0;
        pix_interior = 1'b0;
        if (with_gaps) repeat ($urandom_range(1, 3)) next_cycle();
      end
    end
  endtask

  task automatic wait_frame_end(input string name);
    int cycles;
    cycles = 0;
    while (res_total - frame_base < N_RES) begin
      if (cycles == TIMEOUT) stop_with_failure({"timed out waiting for the ", name, " frame"});
      next_cycle();
      cycles++;
    end
    repeat (12) next_cycle();  // room for a stray result to show up
    assert (res_total - frame_base == N_RES && done_total - done_base == 1)
      else stop_with_failure($sformatf("** Error @ %0t: %s frame gave %0d results, %0d done",
                                       $time, name, res_total - frame_base,
                                       done_total - done_base));
  endtask

  // ====================
  // output checking
  // ====================

  always @(negedge clk) begin
    int   idx;
    int   r;
    int   c;
    logic exp_bit;
    if (adaptive_binarize_top_inst.props_inst.err_cnt != 0) begin
      stop_with_failure("a concurrent assertion on the DUT outputs failed");
    end
    if (rst_n && o_bin_valid) begin
      idx = res_total - frame_base;
      if (idx >= N_RES) stop_with_failure("result strobe after the frame was complete");
      r       = WIN - 1 + idx / OUT_COLS;
      c       = WIN - 1 + idx % OUT_COLS;
      exp_bit = expected_bit(r, c, cur_offset);
      assert (o_bin == exp_bit)
        else stop_with_failure($sformatf("** Error @ %0t: row %0d col %0d gave %0b, expected %0b",
                                         $time, r, c, o_bin, exp_bit));
      // the leftmost window lies in the flat block, the rightmost centre in the square
      assert (!pattern_mode || c != WIN - 1 || o_bin == (cur_offset == '0))
        else stop_with_failure($sformatf("** Error @ %0t: flat window at row %0d wrong", $time, r));
      assert (!pattern_mode || c != COLS - 1 || o_bin)
        else stop_with_failure($sformatf("** Error @ %0t: square pixel at row %0d not set",
                                         $time, r));
      res_total = res_total + 1;
    end
    if (rst_n && o_frame_done) begin
      assert (res_total - frame_base == N_RES - 1)
        else stop_with_failure($sformatf("** Error @ %0t: frame done after %0d results",
                                         $time, res_total - frame_base));
      done_total = done_total + 1;
    end
  end

  // ====================
  // stimulus
  // ====================

  initial begin
    rst_n         = 1'b0;
    i_frame_start = 1'b0;
    i_pix_valid   = 1'b0;
    i_pix         = '0;
    i_offset      = '0;
    pix_interior  = 1'b0;
    pattern_mode  = 1'b0;
    cur_offset    = '0;
    frame_base    = 0;
    done_base     = 0;
    void'($urandom(32'hb24e_81dc));
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (3) next_cycle();
    foreach (img[r, c]) img[r][c] = pixel_t'($urandom_range(0, 255));
    send_frame(box_sum_t'(0), 1'b0);
    wait_frame_end("random");
    foreach (img[r, c]) img[r][c] = pixel_t'($urandom_range(0, 255));
    send_frame(box_sum_t'(300), 1'b1);
    wait_frame_end("gapped");
    // flat block at 40 with a bright square at 200 on its right side
    foreach (img[r, c]) img[r][c] = (r >= 4 && r <= 11 && c >= 13) ? 8'd200 : 8'd40;
    pattern_mode = 1'b1;
    send_frame(box_sum_t'(0), 1'b0);
    wait_frame_end("pattern with zero offset");
    send_frame(box_sum_t'(100), 1'b0);
    wait_frame_end("pattern with positive offset");
    if (adaptive_binarize_top_inst.props_inst.err_cnt == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_with_failure("a concurrent assertion failed near the end of the run");
    end
  end

endmodule

// ==== test/binarize_props.sv ====
`timescale 1ns/1ns

module binarize_props
  import binarize_pkg::*;
#(
  parameter int COLS = 64,
  parameter int ROWS = 48
) (
  input logic clk,
  input logic rst_n,
  input logic i_frame_start,
  input logic i_pix_interior,
  input logic i_bin_valid,
  input logic i_frame_done
);

  localparam int N_RES   = (ROWS - (WIN - 1)) * (COLS - (WIN - 1));
  localparam int LATENCY = 7;  // pixel in to result out

  int err_cnt = 0;
  int bin_cnt;
  int done_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n || i_frame_start) begin
      bin_cnt  <= 0;
      done_cnt <= 0;
    end else begin
      bin_cnt  <= bin_cnt + (i_bin_valid ? 1 : 0);
      done_cnt <= done_cnt + (i_frame_done ? 1 : 0);
    end
  end

  latency_check: assert property (@(posedge clk) disable iff (!rst_n)
    i_bin_valid == $past(i_pix_interior, LATENCY))
    else begin
      err_cnt++;
      $error("result strobe without an interior pixel %0d cycles earlier", LATENCY);
    end

  // the last result of a frame follows the done pulse by one cycle
  done_last: assert property (@(posedge clk) disable iff (!rst_n)
    $past(i_frame_done) |-> (i_bin_valid && bin_cnt == N_RES - 1))
    else begin
      err_cnt++;
      $error("frame done pulse not followed by the last result");
    end

  done_once: assert property (@(posedge clk) disable iff (!rst_n)
    i_frame_done |-> (done_cnt == 0))
    else begin
      err_cnt++;
      $error("second frame done pulse in one frame");
    end

  quiet_after_reset: assert property (@(posedge clk)
    (rst_n && !$past(rst_n)) |-> (!i_bin_valid && !i_frame_done))
    else begin
      err_cnt++;
      $error("output strobe active right after reset");
    end

  quiet_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    $past(i_frame_start) |-> (!i_bin_valid && !i_frame_done))
    else begin
      err_cnt++;
      $error("output strobe active right after frame start");
    end

endmodule

// ==== logic/adaptive_binarize_top.sv ====
`timescale 1ns/1ns

module adaptive_binarize_top
  import binarize_pkg::*;
#(
  parameter int COLS = 64,
  parameter int ROWS = 48
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_frame_start,
  input  logic     i_pix_valid,
  input  pixel_t   i_pix,
  input  box_sum_t i_offset,
  output logic     o_bin_valid,
  output logic     o_bin,
  output logic     o_frame_done
);

  logic             col_valid;
  pixel_t           col [WIN];
  logic [IDX_W-1:0] col_idx;
  logic             win_valid;
  box_sum_t         box_sum;
  pixel_t           center;

  line_tap_buffer #(
    .COLS (COLS)
  ) line_tap_buffer_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_frame_start (i_frame_start),
    .i_pix_valid   (i_pix_valid),
    .i_pix         (i_pix),
    .o_col_valid   (col_valid),
    .o_col         (col),
    .o_col_idx     (col_idx)
  );

  window_sum #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) window_sum_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_frame_start (i_frame_start),
    .i_col_valid   (col_valid),
    .i_col         (col),
    .i_col_idx     (col_idx),
    .o_win_valid   (win_valid),
    .o_box_sum     (box_sum),
    .o_center      (center),
    .o_frame_done  (o_frame_done)
  );

  threshold_decide threshold_decide_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_win_valid (win_valid),
    .i_box_sum   (box_sum),
    .i_center    (center),
    .i_offset    (i_offset),
    .o_bin_valid (o_bin_valid),
    .o_bin       (o_bin)
  );

endmodule

// ==== logic/threshold_decide.sv ====
`timescale 1ns/1ns

module threshold_decide
  import binarize_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_win_valid,
  input  box_sum_t i_box_sum,
  input  pixel_t   i_center,
  input  box_sum_t i_offset,
  output logic     o_bin_valid,
  output logic     o_bin
);

  localparam int CMP_W = $bits(box_sum_t) + 1;  // room for sum plus offset

  logic [CMP_W-1:0] scaled;
  logic [CMP_W-1:0] limit;

  // centre times area against the box sum is the mean test without a divide
  assign scaled = CMP_W'(i_center) * CMP_W'(WIN_AREA);
  assign limit  = CMP_W'(i_box_sum) + CMP_W'(i_offset);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_bin_valid <= 1'b0;
    end else begin
      o_bin_valid <= i_win_valid;
    end
  end

  always_ff @(posedge clk) begin
    o_bin <= (scaled >= limit);
  end

endmodule

// ==== logic/window_sum.sv ====
`timescale 1ns/1ns

module window_sum
  import binarize_pkg::*;
#(
  parameter int COLS = 64,
  parameter int ROWS = 48
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_frame_start,
  input  logic             i_col_valid,
  input  pixel_t           i_col [WIN],
  input  logic [IDX_W-1:0] i_col_idx,
  output logic             o_win_valid,
  output box_sum_t         o_box_sum,
  output pixel_t           o_center,
  output logic             o_frame_done
);

  logic [8:0]       lvl1 [7];
  logic [9:0]       lvl2 [4];
  logic [10:0]      lvl3 [2];
  col_sum_t         col_sum;
  col_sum_t         col_old;
  logic [3:0]       vld_pipe;
  logic [IDX_W-1:0] idx_pipe [4];
  pixel_t           ctr_pipe [4];
  pixel_t           ctr_tap;
  logic [IDX_W-1:0] row_cnt;
  logic             idx_first;
  logic             idx_full;
  logic             idx_last;
  logic             row_last;
  logic             win_inside;
  box_sum_t         col_drop;

  // ====================
  // column adder tree
  // ====================

  // four registered levels, 13 -> 7 -> 4 -> 2 -> 1
  always_ff @(posedge clk) begin
    for (int k = 0; k < 6; k++) begin
      lvl1[k] <= 9'(i_col[2*k]) + 9'(i_col[2*k+1]);
    end
    lvl1[6] <= 9'(i_col[WIN-1]);
    for (int k = 0; k < 3; k++) begin
      lvl2[k] <= 10'(lvl1[2*k]) + 10'(lvl1[2*k+1]);
    end
    lvl2[3] <= 10'(lvl1[6]);
    lvl3[0] <= 11'(lvl2[0]) + 11'(lvl2[1]);
    lvl3[1] <= 11'(lvl2[2]) + 11'(lvl2[3]);
    col_sum <= col_sum_t'(lvl3[0]) + col_sum_t'(lvl3[1]);
    idx_pipe[0] <= i_col_idx;
    ctr_pipe[0] <= ctr_tap;
    for (int k = 1; k < 4; k++) begin
      idx_pipe[k] <= idx_pipe[k-1];
      ctr_pipe[k] <= ctr_pipe[k-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else if (i_frame_start) begin
      vld_pipe <= '0;  // drop anything still in flight from the last frame
    end else begin
      vld_pipe <= {vld_pipe[2:0], i_col_valid};
    end
  end

  // centre of the window is row tap 6 of the column six places back
  delay_line #(
    .T     (pixel_t),
    .DEPTH (WIN_HALF)
  ) ctr_delay_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .i_en  (i_col_valid),
    .i_d   (i_col[WIN_HALF]),
    .o_q   (ctr_tap)
  );

  // ====================
  // running box sum
  // ====================

  delay_line #(
    .T     (col_sum_t),
    .DEPTH (WIN)
  ) col_hist_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .i_en  (vld_pipe[3]),
    .i_d   (col_sum),
    .o_q   (col_old)
  );

  assign idx_first  = (idx_pipe[3] == '0);
  assign idx_full   = (idx_pipe[3] >= IDX_W'(WIN));
  assign idx_last   = (idx_pipe[3] == IDX_W'(COLS - 1));
  assign row_last   = (row_cnt == IDX_W'(ROWS - 1));
  assign win_inside = (idx_pipe[3] >= IDX_W'(WIN - 1)) && (row_cnt >= IDX_W'(WIN - 1));
  assign col_drop   = idx_full ? box_sum_t'(col_old) : '0;  // column leaving the window

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_box_sum    <= '0;
      row_cnt      <= '0;
      o_win_valid  <= 1'b0;
      o_frame_done <= 1'b0;
    end else if (i_frame_start) begin
      row_cnt      <= '0;
      o_win_valid  <= 1'b0;
      o_frame_done <= 1'b0;
    end else begin
      o_win_valid  <= vld_pipe[3] && win_inside;
      o_frame_done <= vld_pipe[3] && idx_last && row_last;
      if (vld_pipe[3]) begin
        o_box_sum <= idx_first ? box_sum_t'(col_sum)
                               : o_box_sum + box_sum_t'(col_sum) - col_drop;
        if (idx_last) begin
          row_cnt <= row_last ? '0 : row_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vld_pipe[3]) begin
      o_center <= ctr_pipe[3];
    end
  end

endmodule

// ==== logic/line_tap_buffer.sv ====
`timescale 1ns/1ns

module line_tap_buffer
  import binarize_pkg::*;
#(
  parameter int COLS = 64
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_frame_start,
  input  logic             i_pix_valid,
  input  pixel_t           i_pix,
  output logic             o_col_valid,
  output pixel_t           o_col [WIN],
  output logic [IDX_W-1:0] o_col_idx
);

  localparam int LINES  = WIN - 1;
  localparam int ADDR_W = $clog2(COLS);

  pixel_t line_mem [LINES][COLS];  // row 0 is the oldest stored line

  logic [IDX_W-1:0]  col_cnt;
  logic [ADDR_W-1:0] col_addr;
  logic              col_last;

  assign col_addr = col_cnt[ADDR_W-1:0];
  assign col_last = (col_cnt == IDX_W'(COLS - 1));

  // ====================
  // column position
  // ====================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt     <= '0;
      o_col_valid <= 1'b0;
    end else if (i_frame_start) begin
      col_cnt     <= '0;
      o_col_valid <= 1'b0;
    end else begin
      o_col_valid <= i_pix_valid;
      if (i_pix_valid) begin
        col_cnt <= col_last ? '0 : col_cnt + 1'b1;
      end
    end
  end

  // ====================
  // line storage
  // ====================

  // each stored column moves up one row and the new pixel goes in at the bottom
  always_ff @(posedge clk) begin
    if (i_pix_valid) begin
      for (int k = 0; k < LINES - 1; k++) begin
        line_mem[k][col_addr] <= line_mem[k+1][col_addr];
        o_col[k]              <= line_mem[k][col_addr];
      end
      line_mem[LINES-1][col_addr] <= i_pix;
      o_col[LINES-1]              <= line_mem[LINES-1][col_addr];
      o_col[WIN-1]                <= i_pix;  // current row sits at the top index
      o_col_idx                   <= col_cnt;
    end
  end

endmodule

// ==== logic/delay_line.sv ====
`timescale 1ns/1ns

module delay_line #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic i_en,
  input  T     i_d,
  output T     o_q
);

  T stage [DEPTH];

  // the chain only moves when an item is accepted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < DEPTH; k++) begin
        stage[k] <= '0;
      end
    end else if (i_en) begin
      stage[0] <= i_d;
      for (int k = 1; k < DEPTH; k++) begin
        stage[k] <= stage[k-1];
      end
    end
  end

  // read beside an accepting item this is the item DEPTH places older
  assign o_q = stage[DEPTH-1];

endmodule

// ==== logic/binarize_pkg.sv ====
package binarize_pkg;

  // ====================
  // pixel and sum types
  // ====================

  typedef logic [7:0] pixel_t;    // unsigned grey value

  typedef logic [11:0] col_sum_t; // 13 pixels of 255 at most give 3315

  typedef logic [15:0] box_sum_t; // 169 pixels of 255 at most give 43095

  // ====================
  // window geometry
  // ====================

  localparam int WIN = 13;

  localparam int WIN_HALF = WIN / 2;    // centre row and column offset

  localparam int WIN_AREA = WIN * WIN;

  localparam int IDX_W = 10;            // row and column index width

endpackage
